// File: source/ls_pkg.sv
// Memory stage shared definitions
`default_nettype none

package ls_pkg;

  localparam int TAG_W        = 6;
  localparam int XLEN         = 32;
  localparam int ISSUE_DEPTH  = 4;
  localparam int RESULT_DEPTH = 4;
  localparam int CACHE_LINES  = 16;   // One word per line.
  localparam int MEM_WORDS    = 256;  // 1 KiB.
  localparam int MEM_LATENCY  = 2;

  localparam int MEM_AW  = $clog2(MEM_WORDS);    // Word address bits.
  localparam int INDEX_W = $clog2(CACHE_LINES);
  localparam int CTAG_W  = MEM_AW - INDEX_W;     // Cache tag bits.

  typedef enum logic [3:0] {
    NONE, LB, LBU, LH, LHU, LW, SB, SH, SW
  } ls_op_e;

  typedef enum logic [1:0] {
    WORD = 2'd0,
    HALF = 2'd1,
    BYTE = 2'd2
  } store_type_e;

  typedef struct packed {
    ls_op_e            op;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   data_1;     // Base register.
    logic [XLEN-1:0]   data_2;     // Store data.
    logic [XLEN-1:0]   immediate;
  } ls_entry_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic              is_store;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   result_address;
  } ls_result_t;

  typedef struct packed {
    logic [XLEN-1:0]   address;
    logic              read;
    logic              write;
    store_type_e       store_type;
    logic [XLEN-1:0]   wdata;
    logic [TAG_W-1:0]  tag;
  } cache_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   rdata;      // Addressed lane at bit 0.
    logic              hit;
    logic              done;
  } cache_rsp_t;

  typedef struct packed {
    logic [MEM_AW-1:0] addr;
    logic              read;
    logic              write;
    logic [XLEN-1:0]   wdata;
    logic [3:0]        byte_en;
  } mem_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   rdata;
    logic              ack;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/ls_fifo.sv
// Synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module ls_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic clock,
  input  logic arst_n,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic full,
  output logic empty
);

  T                             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH + 1)-1:0] count;
  logic                         do_push;
  logic                         do_pop;

  assign full    = (count == DEPTH);
  assign empty   = (count == 0);
  assign do_push = push & ~full;   // Dropped when full.
  assign do_pop  = pop & ~empty;
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
// Load/store resolution
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  ls_pkg::ls_entry_t  entry,
  input  logic               entry_valid,
  input  logic               result_full,
  input  ls_pkg::cache_rsp_t cache_rsp,
  output ls_pkg::cache_req_t cache_req,
  output ls_pkg::ls_result_t result,
  output logic               done
);
  import ls_pkg::*;

  logic [XLEN-1:0] address;
  logic            active;
  logic            load_op;
  logic            store_op;
  logic [7:0]      rd_byte;
  logic [15:0]     rd_half;

  assign address  = entry.data_1 + entry.immediate;
  assign active   = entry_valid & ~result_full;  // Waits while results back up.
  assign load_op  = entry.op inside {LB, LBU, LH, LHU, LW};
  assign store_op = entry.op inside {SB, SH, SW};
  assign rd_byte  = cache_rsp.rdata[7:0];
  assign rd_half  = cache_rsp.rdata[15:0];

  // Request stays up through the finishing cycle, so hit never feeds back into read.
  always_comb begin
    cache_req = '0;
    result    = '0;
    done      = 1'b0;

    if (active && load_op) begin
      cache_req.address = address;
      cache_req.read    = 1'b1;
      cache_req.tag     = entry.tag;

      if (cache_rsp.hit) begin
        done       = 1'b1;
        result.tag = entry.tag;
        case (entry.op)
          LB:      result.result = {{(XLEN - 8){rd_byte[7]}}, rd_byte};
          LBU:     result.result = {{(XLEN - 8){1'b0}}, rd_byte};
          LH:      result.result = {{(XLEN - 16){rd_half[15]}}, rd_half};
          LHU:     result.result = {{(XLEN - 16){1'b0}}, rd_half};
          default: result.result = cache_rsp.rdata;
        endcase
      end
    end else if (active && store_op) begin
      cache_req.address = address;
      cache_req.write   = 1'b1;
      cache_req.wdata   = entry.data_2;
      cache_req.tag     = entry.tag;
      case (entry.op)
        SB:      cache_req.store_type = BYTE;
        SH:      cache_req.store_type = HALF;
        default: cache_req.store_type = WORD;
      endcase

      if (cache_rsp.done) begin
        done                  = 1'b1;
        result.tag            = entry.tag;
        result.is_store       = 1'b1;
        result.result         = entry.data_2;
        result.result_address = address;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/data_cache.sv
// Direct-mapped write-through data cache
`timescale 1ns/1ps
`default_nettype none

module data_cache (
  input  logic               clock,
  input  logic               arst_n,
  input  ls_pkg::cache_req_t req,
  output ls_pkg::cache_rsp_t rsp,
  output ls_pkg::mem_req_t   mem_req,
  input  ls_pkg::mem_rsp_t   mem_rsp
);
  import ls_pkg::*;

  typedef enum logic [1:0] {IDLE, REFILL, WRITE} cache_state_e;

  cache_state_e           state;
  logic [XLEN-1:0]        line_data [CACHE_LINES];
  logic [CTAG_W-1:0]      line_tag  [CACHE_LINES];
  logic [CACHE_LINES-1:0] line_valid;

  logic [MEM_AW-1:0]      word_addr;
  logic [INDEX_W-1:0]     index;
  logic [CTAG_W-1:0]      addr_tag;
  logic [1:0]             byte_off;
  logic [3:0]             byte_en;
  logic [XLEN-1:0]        wdata_lanes;
  logic                   hit;

  // Captured in IDLE and held for the memory access.
  logic [MEM_AW-1:0]      pend_addr;
  logic [XLEN-1:0]        pend_wdata;
  logic [3:0]             pend_be;
  logic [INDEX_W-1:0]     pend_index;
  logic [CTAG_W-1:0]      pend_tag;
  logic                   pend_present;

  assign word_addr   = req.address[MEM_AW+1:2];
  assign index       = word_addr[INDEX_W-1:0];
  assign addr_tag    = word_addr[MEM_AW-1:INDEX_W];
  assign byte_off    = req.address[1:0];
  assign hit         = req.read & line_valid[index] & (line_tag[index] == addr_tag);
  assign wdata_lanes = req.wdata << {byte_off, 3'b000};

  assign pend_index   = pend_addr[INDEX_W-1:0];
  assign pend_tag     = pend_addr[MEM_AW-1:INDEX_W];
  assign pend_present = line_valid[pend_index] & (line_tag[pend_index] == pend_tag);

  always_comb begin
    case (req.store_type)
      HALF:    byte_en = 4'b0011 << byte_off;
      BYTE:    byte_en = 4'b0001 << byte_off;
      default: byte_en = 4'b1111;
    endcase
  end

  always_comb begin
    rsp.rdata = line_data[index] >> {byte_off, 3'b000};  // Lane down to bit 0.
    rsp.hit   = hit;
    rsp.done  = (state == WRITE) & mem_rsp.ack;
  end

  always_comb begin
    mem_req.addr    = pend_addr;
    mem_req.read    = (state == REFILL);
    mem_req.write   = (state == WRITE);
    mem_req.wdata   = pend_wdata;
    mem_req.byte_en = pend_be;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      line_valid <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req.read && !hit) begin
            state <= REFILL;
          end else if (req.write) begin
            state <= WRITE;  // Always through to memory.
          end
        end
        REFILL: begin
          if (mem_rsp.ack) begin
            state                  <= IDLE;
            line_valid[pend_index] <= 1'b1;
          end
        end
        WRITE: begin
          if (mem_rsp.ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE) begin
      pend_addr  <= word_addr;
      pend_wdata <= wdata_lanes;
      pend_be    <= byte_en;
    end
    if (state == REFILL && mem_rsp.ack) begin
      line_data[pend_index] <= mem_rsp.rdata;
      line_tag[pend_index]  <= pend_tag;
    end
    // No allocate on a store miss.
    if (state == WRITE && mem_rsp.ack && pend_present) begin
      for (int i = 0; i < 4; i++) begin
        if (pend_be[i]) begin
          line_data[pend_index][8*i +: 8] <= pend_wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/main_memory.sv
// Fixed-latency main memory
`timescale 1ns/1ps
`default_nettype none

module main_memory (
  input  logic             clock,
  input  logic             arst_n,
  input  ls_pkg::mem_req_t req,
  output ls_pkg::mem_rsp_t rsp
);
  import ls_pkg::*;

  logic [XLEN-1:0]                    words [MEM_WORDS] = '{default: '0};
  logic [$clog2(MEM_LATENCY + 1)-1:0] wait_cnt;
  logic [XLEN-1:0]                    rd_data;
  logic                               ack;
  logic                               busy;
  logic                               expire;

  assign busy   = (req.read | req.write) & ~ack;  // Request still held after ack.
  assign expire = busy & (wait_cnt == MEM_LATENCY - 1);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
      ack      <= 1'b0;
    end else begin
      ack <= expire;
      if (expire) begin
        wait_cnt <= '0;
      end else if (busy) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (expire && req.write) begin
      for (int i = 0; i < 4; i++) begin
        if (req.byte_en[i]) begin
          words[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
    if (expire && req.read) begin
      rd_data <= words[req.addr];
    end
  end

  always_comb begin
    rsp.rdata = rd_data;
    rsp.ack   = ack;
  end

endmodule

`default_nettype wire

// File: source/ls_subsystem.sv
// Memory stage top level
`timescale 1ns/1ps
`default_nettype none

module ls_subsystem (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               issue_push,
  input  ls_pkg::ls_entry_t  issue_entry,
  output logic               issue_full,
  input  logic               result_pop,
  output ls_pkg::ls_result_t result_out,
  output logic               result_empty
);
  import ls_pkg::*;

  ls_entry_t  head;
  logic       issue_empty;
  logic       head_valid;
  logic       result_full;
  ls_result_t lsu_result;
  logic       lsu_done;   // Pops the head and pushes the result.
  cache_req_t cache_req;
  cache_rsp_t cache_rsp;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;

  assign head_valid = ~issue_empty;

  ls_fifo #(.T(ls_entry_t), .DEPTH(ISSUE_DEPTH)) u_issue_fifo (
    .clock  (clock),
    .arst_n (arst_n),
    .push   (issue_push),
    .din    (issue_entry),
    .pop    (lsu_done),
    .dout   (head),
    .full   (issue_full),
    .empty  (issue_empty)
  );

  load_store_unit u_lsu (
    .entry       (head),
    .entry_valid (head_valid),
    .result_full (result_full),
    .cache_rsp   (cache_rsp),
    .cache_req   (cache_req),
    .result      (lsu_result),
    .done        (lsu_done)
  );

  ls_fifo #(.T(ls_result_t), .DEPTH(RESULT_DEPTH)) u_result_fifo (
    .clock  (clock),
    .arst_n (arst_n),
    .push   (lsu_done),
    .din    (lsu_result),
    .pop    (result_pop),
    .dout   (result_out),
    .full   (result_full),
    .empty  (result_empty)
  );

  data_cache u_cache (
    .clock   (clock),
    .arst_n  (arst_n),
    .req     (cache_req),
    .rsp     (cache_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  main_memory u_memory (
    .clock  (clock),
    .arst_n (arst_n),
    .req    (mem_req),
    .rsp    (mem_rsp)
  );

endmodule

`default_nettype wire

// File: tests/tb_ls_subsystem.sv
// Load/store subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ls_subsystem;
  import ls_pkg::*;

  localparam int NUM_OPS    = 79;
  localparam int MAX_CYCLES = NUM_OPS * (MEM_LATENCY + 4) + 200;

  logic       clock = 1'b0;
  logic       arst_n;
  logic       issue_push;
  ls_entry_t  issue_entry;
  logic       issue_full;
  logic       result_pop;
  ls_result_t result_out;
  logic       result_empty;

  logic [7:0] model_mem [1024] = '{default: 8'h00};  // Byte image of main memory.
  ls_result_t exp_q [$];
  string      name_q [$];
  ls_result_t exp_front = '0;
  string      exp_name = "";
  string      test_name = "";
  logic [5:0] next_tag = '0;
  logic       drain_en = 1'b1;
  integer     seed = 38644;
  int         cycles = 0;
  int         n_issued = 0;
  int         n_popped = 0;
  int         mismatch_errs = 0;
  int         unknown_errs = 0;
  int         order_errs = 0;

  ls_subsystem u_ls_subsystem (
    .clock        (clock),
    .arst_n       (arst_n),
    .issue_push   (issue_push),
    .issue_entry  (issue_entry),
    .issue_full   (issue_full),
    .result_pop   (result_pop),
    .result_out   (result_out),
    .result_empty (result_empty)
  );

  always #5 clock = ~clock;

  function automatic logic [31:0] model_load(input ls_op_e op, input logic [31:0] addr);
    logic [9:0]  a;
    logic [7:0]  b;
    logic [15:0] h;
    a = addr[9:0];
    b = model_mem[a];
    h = {model_mem[a + 10'd1], b};
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'd0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'd0, h};
      default: return {model_mem[a + 10'd3], model_mem[a + 10'd2], h};
    endcase
  endfunction

  function automatic void model_store(input ls_op_e op, input logic [31:0] addr,
                                      input logic [31:0] data);
    logic [9:0]  a;
    logic [31:0] d;
    int          nbytes;
    a = addr[9:0];
    d = data;
    case (op)
      SB:      nbytes = 1;
      SH:      nbytes = 2;
      default: nbytes = 4;
    endcase
    for (int i = 0; i < nbytes; i++) begin
      model_mem[a] = d[7:0];  // Little endian.
      d = d >> 8;
      a = a + 10'd1;
    end
  endfunction

  // Called 1 ns after a rising edge, returns 1 ns after a later one.
  task automatic issue_op(input ls_op_e op, input logic [31:0] base,
                          input logic [31:0] imm, input logic [31:0] data);
    logic [31:0] addr;
    ls_result_t  expected;
    addr = base + imm;
    expected = '0;
    expected.tag = next_tag;
    if (op inside {SB, SH, SW}) begin
      expected.is_store = 1'b1;
      expected.result = data;
      expected.result_address = addr;
      model_store(op, addr, data);
    end else begin
      expected.result = model_load(op, addr);
    end
    while (issue_full) begin
      @(posedge clock);
      #1;
    end
    exp_q.push_back(expected);
    name_q.push_back(test_name);
    issue_entry.op = op;
    issue_entry.tag = next_tag;
    issue_entry.data_1 = base;
    issue_entry.data_2 = data;
    issue_entry.immediate = imm;
    issue_push = 1'b1;
    n_issued++;
    next_tag = next_tag + 6'd1;
    @(posedge clock);
    #1;
    issue_push = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || !result_empty) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic print_counts();
    $display("Errors: mismatch %0d, unknown %0d, order %0d (issued %0d, popped %0d)",
             mismatch_errs, unknown_errs, order_errs, n_issued, n_popped);
  endtask

  // Pops results whenever allowed.
  always @(posedge clock) begin
    #1;
    if (arst_n && drain_en && !result_empty) begin
      extra_check: assert (exp_q.size() > 0) else begin
        order_errs++;
        $display("A result with tag %0d came out that was never issued", result_out.tag);
      end
      if (exp_q.size() > 0) begin
        exp_front = exp_q.pop_front();
        exp_name = name_q.pop_front();
      end
      result_pop = 1'b1;
      n_popped++;
    end else begin
      result_pop = 1'b0;
    end
  end

  result_check: assert property (@(negedge clock) disable iff (!arst_n)
    result_pop |-> result_out == exp_front)
  else begin
    mismatch_errs++;
    $display("ERR %s: expected tag %0d st %0b res %h addr %h, actual tag %0d st %0b res %h addr %h",
             exp_name, exp_front.tag, exp_front.is_store, exp_front.result,
             exp_front.result_address, result_out.tag, result_out.is_store,
             result_out.result, result_out.result_address);
  end

  known_check: assert property (@(negedge clock) disable iff (!arst_n)
    !$isunknown({result_empty, issue_full}))
  else begin
    unknown_errs++;
    $display("result_empty or issue_full is unknown after reset");
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: results stopped arriving after %0d cycles", cycles);
      print_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] imm;
    logic [31:0] rnd;
    logic [31:0] line_a;
    logic [31:0] line_b;
    ls_op_e      op;
    arst_n      = 1'b0;
    issue_push  = 1'b0;
    issue_entry = '0;
    result_pop  = 1'b0;
    repeat (4) @(posedge clock);
    #1;
    arst_n = 1'b1;
    @(posedge clock);
    #1;

    test_name = "word_store_load";
    issue_op(SW, 32'h100, 32'h10, 32'hDEAD_BEEF);
    issue_op(LW, 32'h110, 32'h0, 32'h0);
    issue_op(LW, 32'h120, -32'h10, 32'h0);  // Second one hits.
    wait_drained();

    test_name = "byte_half_merge";
    issue_op(SW, 32'h200, 32'h0, 32'h1122_3344);
    issue_op(SB, 32'h200, 32'h1, 32'h0000_00A5);
    issue_op(SH, 32'h200, 32'h2, 32'h0000_BEEF);
    issue_op(SB, 32'h1FC, 32'h4, 32'hFFFF_FF5A);
    issue_op(LW, 32'h200, 32'h0, 32'h0);
    wait_drained();

    test_name = "load_extend";
    issue_op(SW, 32'h240, 32'h0, 32'h80F0_7F8C);
    issue_op(LB, 32'h240, 32'h0, 32'h0);
    issue_op(LBU, 32'h240, 32'h0, 32'h0);
    issue_op(LB, 32'h240, 32'h1, 32'h0);
    issue_op(LBU, 32'h240, 32'h3, 32'h0);
    issue_op(LH, 32'h240, 32'h0, 32'h0);
    issue_op(LH, 32'h240, 32'h2, 32'h0);
    issue_op(LHU, 32'h240, 32'h2, 32'h0);
    wait_drained();

    test_name = "line_conflict";
    line_a = 32'h0C8;
    line_b = line_a + CACHE_LINES * 4;  // Same index, other tag.
    for (int i = 0; i < 3; i++) begin
      issue_op(LW, line_b, 32'h0, 32'h0);
      issue_op(SB, line_b, i, $random(seed));
      issue_op(LW, line_b, 32'h0, 32'h0);  // Hits the merged line.
      issue_op(SW, line_a, 32'h0, $random(seed));
      issue_op(LW, line_a, 32'h0, 32'h0);
    end
    wait_drained();

    test_name = "back_pressure";
    @(negedge clock);
    drain_en = 1'b0;
    @(posedge clock);
    #1;
    for (int i = 0; i < 4; i++) begin
      issue_op(SW, 32'h300, 4 * i, 32'hA000_0000 + i);
      issue_op(LW, 32'h300, 4 * i, 32'h0);
    end
    while (!issue_full) begin  // Waits until results back up into the issue FIFO.
      @(posedge clock);
      #1;
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    drain_en = 1'b1;
    @(posedge clock);
    #1;
    wait_drained();

    test_name = "random_mix";
    for (int i = 0; i < 40; i++) begin
      rnd  = $random(seed);
      op   = ls_op_e'({1'b0, rnd[2:0]} + 4'd1);
      addr = {22'd0, rnd[8:3], rnd[10:9], 2'b00} >> 2;  // 64 words.
      if (op inside {LH, LHU, SH}) begin
        addr[0] = 1'b0;
      end else if (op inside {LW, SW}) begin
        addr[1:0] = 2'b00;
      end
      imm = {{27{rnd[15]}}, rnd[15:11]};
      issue_op(op, addr - imm, imm, $random(seed));
    end
    wait_drained();

    repeat (4) @(posedge clock);
    #1;
    end_check: assert (result_empty && n_popped == n_issued) else begin
      order_errs++;
      $display("Results were lost or duplicated: issued %0d, popped %0d", n_issued, n_popped);
    end
    print_counts();
    if (mismatch_errs + unknown_errs + order_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
source/ls_pkg.sv
source/ls_fifo.sv
source/load_store_unit.sv
source/data_cache.sv
source/main_memory.sv
source/ls_subsystem.sv
tests/tb_ls_subsystem.sv

// File: Makefile
TOP := tb_ls_subsystem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
